// File: Makefile
VERILATOR ?= verilator
TOP       ?= tape_player_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tape_player_chk.sv
`timescale 1ns/1ps
`default_nettype none

module tape_player_chk (
	input logic CLK,
	input logic RESET,
	input logic dl_download,
	input logic cass_in,
	input logic tape_out,
	input logic playing
);

	// Idle right after reset
	reset_idle: assert property (@(posedge CLK) RESET |=> !playing)
		else $error("playing high in the cycle after reset");

	// Real cassette input owns the output while idle
	idle_pass: assert property (@(posedge CLK) disable iff (RESET)
		!playing |-> tape_out == cass_in)
		else $error("tape_out differs from cass_in while idle");

	////////////////////
	// Download holds the player off

	no_start_in_download: assert property (@(posedge CLK) disable iff (RESET)
		$rose(playing) |-> !$past(dl_download))
		else $error("playing rose during a download");

endmodule

bind tape_player tape_player_chk chk0 (
	.CLK         (CLK),
	.RESET       (RESET),
	.dl_download (dl_download),
	.cass_in     (cass_in),
	.tape_out    (tape_out),
	.playing     (playing)
);

`default_nettype wire

// File: dv/tape_player_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tape_player_tb import tape_pkg::*; ();

	localparam int ADDR_W    = DEF_ADDR_W;
	localparam int NUM_BYTES = 3;
	localparam int SETTLE    = 6; // Covers the bit and byte turnaround
	localparam int BTN_PLAY  = 0;
	localparam int BTN_STOP  = 1;
	localparam int BTN_REW   = 2;

	logic              CLK;
	logic              RESET;
	logic              dl_download;
	logic              dl_we;
	logic [ADDR_W-1:0] dl_addr;
	byte_t             dl_data;
	logic              play;
	logic              stop;
	logic              rewind;
	logic              tape_read;
	logic              cass_in;
	logic              tape_out;
	logic              playing;

	integer seed;
	byte_t  image [NUM_BYTES];
	int     byte_start [NUM_BYTES + 1]; // First step index of each byte
	logic   exp_bits [$];               // Expected tape_out per pattern step
	int     cycles;

	tape_player #(
		.ADDR_W (ADDR_W)
	) dut0 (
		.CLK (CLK), .RESET (RESET), .dl_download (dl_download), .dl_we (dl_we),
		.dl_addr (dl_addr), .dl_data (dl_data), .play (play), .stop (stop),
		.rewind (rewind), .tape_read (tape_read), .cass_in (cass_in),
		.tape_out (tape_out), .playing (playing)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	////////////////////
	// Helpers

	task abort_run(input string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1);
	endtask

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task wait_cycles(input int n);
		repeat (n) @(posedge CLK);
	endtask

	// Samples at falling edges until playing reaches the level
	task wait_playing(input logic level, input int limit, output int count);
		count = 0;
		do begin
			@(negedge CLK);
			count++;
		end while (playing !== level && count < limit);
		if (playing !== level)
			abort_run($sformatf("playing did not go to %0d within %0d cycles", level, limit));
	endtask

	task pulse_button(input int which);
		@(posedge CLK);
		case (which)
			BTN_PLAY: play   <= 1'b1;
			BTN_STOP: stop   <= 1'b1;
			default:  rewind <= 1'b1;
		endcase
		@(posedge CLK);
		play   <= 1'b0;
		stop   <= 1'b0;
		rewind <= 1'b0;
	endtask

	task strobe_once(); // One high cycle, three low
		@(posedge CLK);
		tape_read <= 1'b1;
		@(posedge CLK);
		tape_read <= 1'b0;
		repeat (2) @(posedge CLK);
	endtask

	task download_image();
		logic [31:0] r;
		for (int b = 0; b < NUM_BYTES; b++) begin
			r = $random(seed);
			image[b] = r[7:0];
			@(posedge CLK);
			dl_download <= 1'b1;
			dl_we       <= 1'b1;
			dl_addr     <= ADDR_W'(b);
			dl_data     <= image[b];
			if (b == NUM_BYTES - 1)
				play <= 1'b1; // Play edge while still downloading
		end
		@(posedge CLK);
		dl_download <= 1'b0;
		dl_we       <= 1'b0;
		play        <= 1'b0;
		@(negedge CLK) check_value("playing", 32'(playing), 32'h0);
	endtask

	// A one bit plays 0,0,1,1,1,1 twice and a zero bit plays 0,0 then eleven ones
	task build_expected();
		exp_bits.delete();
		for (int b = 0; b < NUM_BYTES; b++) begin
			byte_start[b] = exp_bits.size();
			for (int i = 7; i >= 0; i--) begin
				if (image[b][i])
					for (int k = 0; k < 12; k++) exp_bits.push_back((k % 6) >= 2);
				else
					for (int k = 0; k < 13; k++) exp_bits.push_back(k >= 2);
			end
		end
		byte_start[NUM_BYTES] = exp_bits.size();
	endtask

	// Checks each step just before its first strobe
	task play_steps(input int first, input int last);
		for (int i = first; i < last; i++) begin
			wait_cycles(SETTLE);
			@(negedge CLK);
			check_value($sformatf("tape_out[step %0d]", i), 32'(tape_out), 32'(exp_bits[i]));
			repeat (PULSES_PER_STEP) strobe_once();
		end
	endtask

	task start_playback();
		pulse_button(BTN_PLAY);
		wait_playing(1'b1, 3, cycles);
	endtask

	task stop_playback();
		pulse_button(BTN_STOP);
		wait_playing(1'b0, 2, cycles);
	endtask

	////////////////////
	// Tests

	task test_reset_idle();
		@(negedge CLK);
		check_value("playing", 32'(playing), 32'h0);
		@(posedge CLK) cass_in <= 1'b1;
		@(negedge CLK) check_value("tape_out", 32'(tape_out), 32'h1);
		@(posedge CLK) cass_in <= 1'b0;
		@(negedge CLK) check_value("tape_out", 32'(tape_out), 32'h0);
		pulse_button(BTN_PLAY); // Nothing loaded yet
		wait_cycles(4);
		@(negedge CLK) check_value("playing", 32'(playing), 32'h0);
	endtask

	task test_full_playback();
		download_image();
		build_expected();
		start_playback();
		play_steps(0, byte_start[NUM_BYTES]);
		wait_playing(1'b0, 4, cycles);
	endtask

	task test_stop_resume();
		pulse_button(BTN_REW);
		start_playback();
		play_steps(0, byte_start[1] + 5);
		stop_playback();
		check_value("tape_out", 32'(tape_out), 32'(cass_in));
		@(posedge CLK) cass_in <= 1'b1;
		@(negedge CLK) check_value("tape_out", 32'(tape_out), 32'h1);
		@(posedge CLK) cass_in <= 1'b0;
		start_playback(); // Picks up at the third byte
		play_steps(byte_start[2], byte_start[3]);
		wait_playing(1'b0, 4, cycles);
	endtask

	task test_rewind();
		pulse_button(BTN_REW);
		start_playback();
		play_steps(0, 5);
		stop_playback();
		pulse_button(BTN_REW);
		start_playback();
		play_steps(0, byte_start[1]);
		stop_playback();
	endtask

	task test_timeout();
		pulse_button(BTN_REW);
		start_playback();
		wait_cycles(SETTLE);
		repeat (5) strobe_once();
		wait_playing(1'b0, DEF_TIMEOUT_CYCLES + 20, cycles);
		if (cycles < DEF_TIMEOUT_CYCLES)
			abort_run($sformatf("playback stopped after only %0d idle cycles", cycles));
		check_value("tape_out", 32'(tape_out), 32'(cass_in));
	endtask

	initial begin
		seed        = 32'h91de;
		RESET       <= 1'b1;
		dl_download <= 1'b0;
		dl_we       <= 1'b0;
		dl_addr     <= '0;
		dl_data     <= '0;
		play        <= 1'b0;
		stop        <= 1'b0;
		rewind      <= 1'b0;
		tape_read   <= 1'b0;
		cass_in     <= 1'b0;
		repeat (4) @(posedge CLK);
		RESET <= 1'b0;

		test_reset_idle();
		test_full_playback();
		test_stop_resume();
		test_rewind();
		test_timeout();

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/bit_pattern_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module bit_pattern_shifter import tape_pkg::*; (
	input  logic      CLK,
	input  logic      RESET,
	pattern_if.shifter pat
);

	localparam int BYTE_BITS = $bits(byte_t);
	localparam int BIT_CNT_W = $clog2(BYTE_BITS + 1);
	localparam int PAT_POS_W = $clog2(PATTERN_W + 1);

	byte_t                cur_byte; // Remaining bits, next one at the top
	logic [BIT_CNT_W-1:0] bit_cnt;  // Bits started from this byte
	logic [PATTERN_W-1:0] pattern;  // Bit 0 is the step on the tape
	logic [PAT_POS_W-1:0] pat_pos;  // Position within the pattern

	////////////////////
	// Current byte

	always_ff @(posedge CLK) begin
		if (pat.load_byte)
			cur_byte <= pat.data;
		else if (pat.start_bit)
			cur_byte <= {cur_byte[BYTE_BITS-2:0], 1'b0}; // MSB first
	end

	always_ff @(posedge CLK) begin
		if (RESET || pat.clear || pat.load_byte)
			bit_cnt <= '0;
		else if (pat.start_bit)
			bit_cnt <= bit_cnt + 1'b1;
	end

	////////////////////
	// Pattern shift register

	always_ff @(posedge CLK) begin
		if (RESET || pat.clear) begin
			pattern <= '0;
			pat_pos <= '0;
		end else if (pat.start_bit) begin
			if (cur_byte[BYTE_BITS-1]) begin
				pattern <= PATTERN_ONE;
				pat_pos <= PAT_POS_W'(1); // Twelve steps
			end else begin
				pattern <= PATTERN_ZERO;
				pat_pos <= '0; // Thirteen steps
			end
		end else if (pat.step) begin
			pattern <= pattern >> 1;
			pat_pos <= pat_pos + 1'b1;
		end
	end

	// Status back to the FSM
	assign pat.tape_bit     = pattern[0];
	assign pat.pattern_done = pat_pos == PAT_POS_W'(PATTERN_W);
	assign pat.byte_done    = bit_cnt == BIT_CNT_W'(BYTE_BITS);

endmodule

`default_nettype wire

// File: logic/pattern_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pattern_if import tape_pkg::*; ();

	// FSM to shifter
	logic  load_byte;    // Capture data and restart bit count
	logic  start_bit;    // Load pattern for the byte's top bit
	logic  step;         // Advance one pattern step
	logic  clear;        // Drop the current byte and pattern
	byte_t data;         // Buffer read data, routed in by the top level

	// Shifter to FSM
	logic  byte_done;    // All eight bits started
	logic  pattern_done; // Current pattern fully played
	logic  tape_bit;     // Current pattern step

	modport fsm (
		output load_byte, start_bit, step, clear,
		input  byte_done, pattern_done, tape_bit
	);

	modport shifter (
		input  load_byte, start_bit, step, clear, data,
		output byte_done, pattern_done, tape_bit
	);

endinterface

`default_nettype wire

// File: logic/player_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module player_fsm import tape_pkg::*; (
	input  logic   CLK,
	input  logic   RESET,
	input  logic   dl_download,
	input  logic   play,
	input  logic   stop,
	input  logic   rewind,
	input  logic   at_end,
	input  logic   empty,
	input  logic   step_due,
	input  logic   timed_out,
	output logic   advance,
	output logic   rewind_pos,
	output logic   timer_clear,
	output logic   timer_run,
	output logic   active,
	output logic   playing,
	pattern_if.fsm pat
);

	player_state_t state;
	logic          play_q;
	logic          stop_q;
	logic          rewind_q;
	logic          play_rise;
	logic          stop_rise;
	logic          rewind_rise;
	logic          abort;    // Forced return to idle
	logic          finished; // Image done or reader gone

	////////////////////
	// Control edges

	assign play_rise   = play && !play_q;
	assign stop_rise   = stop && !stop_q;
	assign rewind_rise = rewind && !rewind_q;

	assign abort    = dl_download || stop_rise || rewind_rise;
	assign finished = (state == PLAYER_READ_BYTE && at_end) ||
	                  (state == PLAYER_PLAY_BIT && timed_out);

	////////////////////
	// State register

	always_ff @(posedge CLK) begin
		if (RESET) begin
			state    <= PLAYER_IDLE;
			playing  <= 1'b0;
			play_q   <= 1'b0;
			stop_q   <= 1'b0;
			rewind_q <= 1'b0;
		end else begin
			play_q   <= play;
			stop_q   <= stop;
			rewind_q <= rewind;
			if (abort || finished) begin
				state   <= PLAYER_IDLE;
				playing <= 1'b0;
			end else begin
				case (state)
					PLAYER_IDLE: begin
						if (play_rise && !empty && !at_end) begin
							state   <= PLAYER_READ_BYTE;
							playing <= 1'b1;
						end
					end
					PLAYER_READ_BYTE: state <= PLAYER_NEXT_BIT;
					PLAYER_NEXT_BIT: begin
						if (pat.byte_done)
							state <= PLAYER_READ_BYTE;
						else
							state <= PLAYER_PLAY_BIT;
					end
					PLAYER_PLAY_BIT: begin
						if (pat.pattern_done)
							state <= PLAYER_NEXT_BIT;
					end
					default: state <= PLAYER_IDLE;
				endcase
			end
		end
	end

	////////////////////
	// Pulses to the datapath

	// Byte fetch also moves the buffer to the following byte
	assign pat.load_byte = state == PLAYER_READ_BYTE && !at_end && !abort;
	assign advance       = pat.load_byte;

	assign pat.start_bit = state == PLAYER_NEXT_BIT && !pat.byte_done && !abort;
	assign timer_clear   = pat.start_bit; // Strobe count restarts with each bit

	assign pat.step = state == PLAYER_PLAY_BIT && step_due && !pat.pattern_done &&
	                  !timed_out && !abort;
	assign pat.clear = abort || finished;

	assign rewind_pos = rewind_rise;
	assign timer_run  = state == PLAYER_PLAY_BIT;
	assign active     = state != PLAYER_IDLE;

endmodule

`default_nettype wire

// File: logic/strobe_timer.sv
`timescale 1ns/1ps
`default_nettype none

module strobe_timer import tape_pkg::*; #(
	parameter int TIMEOUT_CYCLES = DEF_TIMEOUT_CYCLES
) (
	input  logic CLK,
	input  logic RESET,
	input  logic tape_read,
	input  logic timer_clear,
	input  logic timer_run,
	output logic step_due,
	output logic timed_out
);

	localparam int PULSE_W = $clog2(PULSES_PER_STEP);
	localparam int IDLE_W  = $clog2(TIMEOUT_CYCLES + 1);

	logic               read_q;
	logic               read_fall;
	logic [PULSE_W-1:0] pulse_cnt;
	logic [IDLE_W-1:0]  idle_cnt;

	always_ff @(posedge CLK) begin
		if (RESET)
			read_q <= 1'b0;
		else
			read_q <= tape_read;
	end

	assign read_fall = read_q && !tape_read; // End of a read strobe

	////////////////////
	// Pulse counter

	always_ff @(posedge CLK) begin
		if (RESET || timer_clear) begin
			pulse_cnt <= '0;
			step_due  <= 1'b0;
		end else if (timer_run && read_fall) begin
			if (pulse_cnt == PULSE_W'(PULSES_PER_STEP - 1)) begin
				pulse_cnt <= '0;
				step_due  <= 1'b1;
			end else begin
				pulse_cnt <= pulse_cnt + 1'b1;
				step_due  <= 1'b0;
			end
		end else begin
			step_due <= 1'b0;
		end
	end

	////////////////////
	// Inactivity timeout

	always_ff @(posedge CLK) begin
		if (RESET || timer_clear)
			idle_cnt <= '0;
		else if (timer_run) begin
			if (read_fall)
				idle_cnt <= '0;
			else if (!timed_out)
				idle_cnt <= idle_cnt + 1'b1; // Saturates at the limit
		end
	end

	assign timed_out = idle_cnt == IDLE_W'(TIMEOUT_CYCLES);

endmodule

`default_nettype wire

// File: logic/tape_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tape_buffer import tape_pkg::*; #(
	parameter int ADDR_W = DEF_ADDR_W
) (
	input  logic              CLK,
	input  logic              RESET,
	input  logic              dl_download,
	input  logic              dl_we,
	input  logic [ADDR_W-1:0] dl_addr,
	input  byte_t             dl_data,
	input  logic              advance,
	input  logic              rewind_pos,
	output byte_t             rd_data,
	output logic              at_end,
	output logic              empty
);

	byte_t             mem [2**ADDR_W];
	logic [ADDR_W-1:0] last_addr;
	logic [ADDR_W:0]   pos; // One extra bit so the position can pass a full buffer

	////////////////////
	// Image memory

	always_ff @(posedge CLK) begin
		if (dl_download && dl_we)
			mem[dl_addr] <= dl_data;
		rd_data <= mem[pos[ADDR_W-1:0]]; // Valid one cycle after pos moves
	end

	////////////////////
	// Last address and read position

	always_ff @(posedge CLK) begin
		if (RESET)
			last_addr <= '0;
		else if (dl_download)
			last_addr <= dl_addr; // Last address seen on the download bus
	end

	always_ff @(posedge CLK) begin
		if (RESET || dl_download || rewind_pos)
			pos <= '0;
		else if (advance)
			pos <= pos + 1'b1;
	end

	assign at_end = pos > {1'b0, last_addr};
	assign empty  = last_addr == '0;

endmodule

`default_nettype wire

// File: logic/tape_pkg.sv
`default_nettype none

package tape_pkg;

	////////////////////
	// Sizes and default parameters

	localparam int DEF_ADDR_W         = 10;   // Tape buffer address width
	localparam int DEF_TIMEOUT_CYCLES = 8192; // Clocks without a read strobe before stopping
	localparam int PULSES_PER_STEP    = 12;   // Read strobes per pattern step
	localparam int PATTERN_W          = 13;   // Pattern length in steps

	////////////////////
	// Bit patterns, played from bit 0 upward

	// One bit starts at position 1 and plays 0,0,1,1,1,1,0,0,1,1,1,1
	localparam logic [PATTERN_W-1:0] PATTERN_ONE  = 13'h0F3C;
	// Zero bit starts at position 0 and plays 0,0 then eleven ones
	localparam logic [PATTERN_W-1:0] PATTERN_ZERO = 13'h1FFC;

	////////////////////
	// Types

	typedef logic [7:0] byte_t;

	typedef enum logic [1:0] {
		PLAYER_IDLE      = 2'd0,
		PLAYER_READ_BYTE = 2'd1, // Fetch next byte from buffer
		PLAYER_NEXT_BIT  = 2'd2, // Pick pattern for next bit
		PLAYER_PLAY_BIT  = 2'd3  // Step pattern on read strobes
	} player_state_t;

endpackage

`default_nettype wire

// File: logic/tape_player.sv
`timescale 1ns/1ps
`default_nettype none

module tape_player import tape_pkg::*; #(
	parameter int ADDR_W         = DEF_ADDR_W,
	parameter int TIMEOUT_CYCLES = DEF_TIMEOUT_CYCLES
) (
	input  logic              CLK,
	input  logic              RESET,
	input  logic              dl_download,
	input  logic              dl_we,
	input  logic [ADDR_W-1:0] dl_addr,
	input  byte_t             dl_data,
	input  logic              play,
	input  logic              stop,
	input  logic              rewind,
	input  logic              tape_read,
	input  logic              cass_in,
	output logic              tape_out,
	output logic              playing
);

	byte_t rd_data;
	logic  at_end;
	logic  empty;
	logic  advance;
	logic  rewind_pos;
	logic  timer_clear;
	logic  timer_run;
	logic  step_due;
	logic  timed_out;
	logic  active;

	pattern_if pat_bus ();

	assign pat_bus.data = rd_data; // Byte fetch path into the shifter

	tape_buffer #(
		.ADDR_W (ADDR_W)
	) buffer0 (
		.CLK         (CLK),
		.RESET       (RESET),
		.dl_download (dl_download),
		.dl_we       (dl_we),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.advance     (advance),
		.rewind_pos  (rewind_pos),
		.rd_data     (rd_data),
		.at_end      (at_end),
		.empty       (empty)
	);

	bit_pattern_shifter shifter0 (
		.CLK   (CLK),
		.RESET (RESET),
		.pat   (pat_bus.shifter)
	);

	strobe_timer #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) timer0 (
		.CLK         (CLK),
		.RESET       (RESET),
		.tape_read   (tape_read),
		.timer_clear (timer_clear),
		.timer_run   (timer_run),
		.step_due    (step_due),
		.timed_out   (timed_out)
	);

	player_fsm fsm0 (
		.CLK         (CLK),
		.RESET       (RESET),
		.dl_download (dl_download),
		.play        (play),
		.stop        (stop),
		.rewind      (rewind),
		.at_end      (at_end),
		.empty       (empty),
		.step_due    (step_due),
		.timed_out   (timed_out),
		.advance     (advance),
		.rewind_pos  (rewind_pos),
		.timer_clear (timer_clear),
		.timer_run   (timer_run),
		.active      (active),
		.playing     (playing),
		.pat         (pat_bus.fsm)
	);

	// Real cassette input passes through while the player is idle
	assign tape_out = active ? pat_bus.tape_bit : cass_in;

endmodule

`default_nettype wire

// File: project.f
logic/tape_pkg.sv
logic/pattern_if.sv
logic/tape_buffer.sv
logic/bit_pattern_shifter.sv
logic/strobe_timer.sv
logic/player_fsm.sv
logic/tape_player.sv
dv/tape_player_chk.sv
dv/tape_player_tb.sv
